/* build.sh */
#!/usr/bin/env bash
# Builds the hazard testbench with Verilator, runs it and checks the log.

set -o pipefail
cd "$(dirname "$0")" || exit 1

LOG=sim.log

rm -rf obj_dir "$LOG"

verilator --binary --timing -j 0 --top-module tb_rv_hazard \
    -f rv_hazard.f -o tb_rv_hazard \
  && ./obj_dir/tb_rv_hazard 2>&1 | tee "$LOG" \
  || { echo "Build or simulation run failed"; exit 1; }

grep -q "Errors found" "$LOG" \
  && { echo "FAIL"; exit 1; } \
  || { echo "PASS"; exit 0; }

/* rtl/rv_hazard_pkg.sv */
`default_nettype none

package rv_hazard_pkg;

  ////////////////////////////////////////////////////////////
  // Encodings and timing constants
  ////////////////////////////////////////////////////////////

  // LUI major opcode.
  localparam logic [6:0] OPC_LUI = 7'b0110111;

  // Result source value used by loads.
  localparam logic [1:0] RES_LOAD = 2'b10;

  // Execute cycles taken by a multiply or divide.
  localparam int MULDIV_LAT = 4;

  // Cycle counter width that can hold MULDIV_LAT.
  localparam int MULDIV_CW = $clog2(MULDIV_LAT + 1);

  ////////////////////////////////////////////////////////////
  // Types
  ////////////////////////////////////////////////////////////

  // Per stage view of one instruction.
  typedef struct packed {
    logic [4:0] rs1;
    logic [4:0] rs2;
    logic [4:0] rd;
    logic [6:0] opcode;
    logic       regw;
    logic [1:0] resultsrc;
    logic       iscsr;
    logic       is_mul;
    logic       is_div;
  } hzd_instr_t;

  // Empty slot in a stage register.
  localparam hzd_instr_t INSTR_BUBBLE = '0;

  // Operand source in execute.
  typedef enum logic [1:0] {
    FWD_NONE    = 2'd0,
    FWD_WB      = 2'd1,
    FWD_MEM     = 2'd2,
    FWD_MEM_LUI = 2'd3
  } fwd_sel_t;

  // Stall and flush controls for the pipeline registers.
  typedef struct packed {
    logic stallpc;
    logic stallfd;
    logic flushfd;
    logic stallde;
    logic flushde;
    logic stallem;
    logic stallmw;
    logic passwb;
  } hzd_ctrl_t;

endpackage

`default_nettype wire

/* rtl/rv_hazard_top.sv */
`default_nettype none

module rv_hazard_top (
  input  wire                       i_clk,
  input  wire                       i_rst_n,
  input  rv_hazard_pkg::hzd_instr_t i_instr,
  input  wire                       i_pcsrc,
  input  wire                       i_dcache_stall,
  output rv_hazard_pkg::fwd_sel_t   o_fwd_a,
  output rv_hazard_pkg::fwd_sel_t   o_fwd_b,
  output rv_hazard_pkg::hzd_ctrl_t  o_ctrl
);

  import rv_hazard_pkg::*;

  hzd_instr_t s_instr_d;
  hzd_instr_t s_instr_e;
  hzd_instr_t s_instr_m;
  hzd_instr_t s_instr_w;
  hzd_ctrl_t  s_ctrl;
  logic       s_muldiv_valid;

  rv_stage_track u_stage_track (
    .i_clk     (i_clk),
    .i_rst_n   (i_rst_n),
    .i_instr   (i_instr),
    .i_ctrl    (s_ctrl),
    .o_instr_d (s_instr_d),
    .o_instr_e (s_instr_e),
    .o_instr_m (s_instr_m),
    .o_instr_w (s_instr_w)
  );

  rv_muldiv_seq u_muldiv_seq (
    .i_clk     (i_clk),
    .i_rst_n   (i_rst_n),
    .i_instr_e (s_instr_e),
    .i_ctrl    (s_ctrl),
    .o_valid   (s_muldiv_valid)
  );

  rv_hazard_unit u_hazard_unit (
    .i_instr_d      (s_instr_d),
    .i_instr_e      (s_instr_e),
    .i_instr_m      (s_instr_m),
    .i_instr_w      (s_instr_w),
    .i_pcsrc        (i_pcsrc),
    .i_dcache_stall (i_dcache_stall),
    .i_muldiv_valid (s_muldiv_valid),
    .o_fwd_a        (o_fwd_a),
    .o_fwd_b        (o_fwd_b),
    .o_ctrl         (s_ctrl)
  );

  assign o_ctrl = s_ctrl;

endmodule

`default_nettype wire

/* rtl/rv_hazard_unit.sv */
`default_nettype none

module rv_hazard_unit (
  input  rv_hazard_pkg::hzd_instr_t i_instr_d,
  input  rv_hazard_pkg::hzd_instr_t i_instr_e,
  input  rv_hazard_pkg::hzd_instr_t i_instr_m,
  input  rv_hazard_pkg::hzd_instr_t i_instr_w,
  input  wire                       i_pcsrc,
  input  wire                       i_dcache_stall,
  input  wire                       i_muldiv_valid,
  output rv_hazard_pkg::fwd_sel_t   o_fwd_a,
  output rv_hazard_pkg::fwd_sel_t   o_fwd_b,
  output rv_hazard_pkg::hzd_ctrl_t  o_ctrl
);

  import rv_hazard_pkg::*;

  logic s_mem_wr;
  logic s_mem_lui;
  logic s_wb_wr;
  logic s_src_match_e;
  logic s_load_use;
  logic s_muldiv_stall;
  logic s_glob_stall;

  ////////////////////////////////////////////////////////////
  // Operand forwarding
  ////////////////////////////////////////////////////////////

  // Memory and writeback stages carrying a live register result.
  assign s_mem_wr  = i_instr_m.regw && (i_instr_m.rd != 5'd0);
  assign s_mem_lui = s_mem_wr && (i_instr_m.opcode == OPC_LUI);
  assign s_wb_wr   = i_instr_w.regw && (i_instr_w.rd != 5'd0);

  // Nearest producer wins and LUI in memory has its own path.
  function automatic fwd_sel_t fwd_select(input logic [4:0] src);
    fwd_sel_t sel;
    if (s_mem_lui && (src == i_instr_m.rd))
    begin
      sel = FWD_MEM_LUI;
    end
    else if (s_mem_wr && (src == i_instr_m.rd))
    begin
      sel = FWD_MEM;
    end
    else if (s_wb_wr && (src == i_instr_w.rd))
    begin
      sel = FWD_WB;
    end
    else
    begin
      sel = FWD_NONE;
    end
    return sel;
  endfunction

  always_comb
  begin
    o_fwd_a = fwd_select(i_instr_e.rs1);
    o_fwd_b = fwd_select(i_instr_e.rs2);
  end

  ////////////////////////////////////////////////////////////
  // Stall and flush
  ////////////////////////////////////////////////////////////

  assign s_src_match_e = (i_instr_d.rs1 == i_instr_e.rd) ||
                         (i_instr_d.rs2 == i_instr_e.rd);

  // CSR read data comes late, like a load, unless decode is a CSR too.
  assign s_load_use = s_src_match_e &&
                      ((i_instr_e.resultsrc == RES_LOAD) ||
                       (i_instr_e.iscsr && !i_instr_d.iscsr));

  assign s_muldiv_stall = (i_instr_e.is_mul | i_instr_e.is_div) & ~i_muldiv_valid;
  assign s_glob_stall   = i_dcache_stall | s_muldiv_stall;

  always_comb
  begin
    o_ctrl         = '0;
    o_ctrl.stallpc = s_load_use | s_glob_stall;
    o_ctrl.stallfd = s_load_use | s_glob_stall;
    o_ctrl.flushfd = i_pcsrc;
    o_ctrl.flushde = s_load_use | i_pcsrc;
    o_ctrl.stallde = s_glob_stall;
    o_ctrl.stallem = s_glob_stall;
    o_ctrl.stallmw = s_glob_stall;
    // Back to back CSRs bypass the writeback value.
    o_ctrl.passwb  = i_instr_m.iscsr & i_instr_w.iscsr;
  end

endmodule

`default_nettype wire

/* rtl/rv_muldiv_seq.sv */
`default_nettype none

module rv_muldiv_seq (
  input  wire                       i_clk,
  input  wire                       i_rst_n,
  input  rv_hazard_pkg::hzd_instr_t i_instr_e,
  input  rv_hazard_pkg::hzd_ctrl_t  i_ctrl,
  output logic                      o_valid
);

  import rv_hazard_pkg::*;

  logic [MULDIV_CW-1:0] r_cnt;
  logic                 s_busy;
  logic                 s_waiting;

  // A long operation sits in execute.
  assign s_busy = i_instr_e.is_mul | i_instr_e.is_div;

  // Result is ready in the last execute cycle of the operation.
  assign o_valid = s_busy && (r_cnt == MULDIV_CW'(MULDIV_LAT - 1));

  // Operation still holding the pipe on its own account.
  assign s_waiting = s_busy & ~o_valid;

  ////////////////////////////////////////////////////////////
  // Cycle counter
  ////////////////////////////////////////////////////////////

  // Stallde high without a waiting operation is a cache stall, so hold.
  always_ff @(posedge i_clk)
  begin
    if (!i_rst_n)
    begin
      r_cnt <= '0;
    end
    else if (!i_ctrl.stallde)
    begin
      r_cnt <= '0;
    end
    else if (s_waiting)
    begin
      r_cnt <= r_cnt + 1'b1;
    end
  end

endmodule

`default_nettype wire

/* rtl/rv_stage_track.sv */
`default_nettype none

module rv_stage_track (
  input  wire                       i_clk,
  input  wire                       i_rst_n,
  input  rv_hazard_pkg::hzd_instr_t i_instr,
  input  rv_hazard_pkg::hzd_ctrl_t  i_ctrl,
  output rv_hazard_pkg::hzd_instr_t o_instr_d,
  output rv_hazard_pkg::hzd_instr_t o_instr_e,
  output rv_hazard_pkg::hzd_instr_t o_instr_m,
  output rv_hazard_pkg::hzd_instr_t o_instr_w
);

  import rv_hazard_pkg::*;

  hzd_instr_t r_instr_d;
  hzd_instr_t r_instr_e;
  hzd_instr_t r_instr_m;
  hzd_instr_t r_instr_w;

  // Next value of one stage register with stall priority over flush.
  function automatic hzd_instr_t stage_next(
    input hzd_instr_t cur,
    input hzd_instr_t nxt,
    input logic       stall,
    input logic       flush
  );
    hzd_instr_t res;
    if (stall)
    begin
      res = cur;
    end
    else if (flush)
    begin
      res = INSTR_BUBBLE;
    end
    else
    begin
      res = nxt;
    end
    return res;
  endfunction

  ////////////////////////////////////////////////////////////
  // Fetch/decode and decode/execute registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge i_clk)
  begin
    if (!i_rst_n)
    begin
      r_instr_d <= INSTR_BUBBLE;
      r_instr_e <= INSTR_BUBBLE;
    end
    else
    begin
      r_instr_d <= stage_next(r_instr_d, i_instr, i_ctrl.stallfd, i_ctrl.flushfd);
      r_instr_e <= stage_next(r_instr_e, r_instr_d, i_ctrl.stallde, i_ctrl.flushde);
    end
  end

  ////////////////////////////////////////////////////////////
  // Execute/memory and memory/writeback registers
  ////////////////////////////////////////////////////////////

  // These stages are never flushed, only held.
  always_ff @(posedge i_clk)
  begin
    if (!i_rst_n)
    begin
      r_instr_m <= INSTR_BUBBLE;
      r_instr_w <= INSTR_BUBBLE;
    end
    else
    begin
      r_instr_m <= stage_next(r_instr_m, r_instr_e, i_ctrl.stallem, 1'b0);
      r_instr_w <= stage_next(r_instr_w, r_instr_m, i_ctrl.stallmw, 1'b0);
    end
  end

  assign o_instr_d = r_instr_d;
  assign o_instr_e = r_instr_e;
  assign o_instr_m = r_instr_m;
  assign o_instr_w = r_instr_w;

endmodule

`default_nettype wire

/* rv_hazard.f */
rtl/rv_hazard_pkg.sv
rtl/rv_stage_track.sv
rtl/rv_muldiv_seq.sv
rtl/rv_hazard_unit.sv
rtl/rv_hazard_top.sv
sim/tb_rv_hazard.sv

/* sim/tb_rv_hazard.sv */
`default_nettype none

module tb_rv_hazard;

  import rv_hazard_pkg::*;

  localparam int CLK_PERIOD = 20;
  localparam int RST_CYCLES = 5;
  localparam int NUM_CYCLES = 3000;

  // Expected responses for one cycle.
  typedef struct packed {
    fwd_sel_t  fwd_a;
    fwd_sel_t  fwd_b;
    hzd_ctrl_t ctrl;
  } hzd_resp_t;

  logic        clk;
  logic        rst_n;
  hzd_instr_t  instr;
  logic        pcsrc;
  logic        dcache_stall;
  fwd_sel_t    fwd_a;
  fwd_sel_t    fwd_b;
  hzd_ctrl_t   ctrl;

  // Shadow copy of the pipeline registers and the long operation counter.
  hzd_instr_t  sh_d;
  hzd_instr_t  sh_e;
  hzd_instr_t  sh_m;
  hzd_instr_t  sh_w;
  int          sh_cnt;
  logic        hold_fetch;

  logic [15:0] lfsr_state;
  int          err_cnt;
  int          check_cnt;
  int          seen_lui;
  int          seen_load_use;
  int          seen_muldiv;
  int          seen_passwb;

  rv_hazard_top UUT (
    .i_clk          (clk),
    .i_rst_n        (rst_n),
    .i_instr        (instr),
    .i_pcsrc        (pcsrc),
    .i_dcache_stall (dcache_stall),
    .o_fwd_a        (fwd_a),
    .o_fwd_b        (fwd_b),
    .o_ctrl         (ctrl)
  );

  initial
  begin
    clk = 1'b0;
    forever
    begin
      #(CLK_PERIOD / 2) clk = ~clk;
    end
  end

  ////////////////////////////////////////////////////////////
  // Stimulus generation
  ////////////////////////////////////////////////////////////

  // Galois LFSR with polynomial x^16 + x^14 + x^13 + x^11 + 1.
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    logic [15:0] nxt;
    nxt = s >> 1;
    if (s[0])
    begin
      nxt = nxt ^ 16'hB400;
    end
    return nxt;
  endfunction

  function automatic logic [7:0] rand_bits(input int n);
    logic [7:0] val;
    val = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr_state = lfsr_step(lfsr_state);
      val = {val[6:0], lfsr_state[0]};
    end
    return val;
  endfunction

  // Addresses use x0 to x3 only so that stage matches are frequent.
  function automatic hzd_instr_t gen_instr();
    hzd_instr_t ins;
    logic [7:0] kind;
    ins        = '0;
    ins.rs1    = 5'(rand_bits(2));
    ins.rs2    = 5'(rand_bits(2));
    ins.rd     = 5'(rand_bits(2));
    ins.regw   = 1'b1;
    ins.opcode = 7'b0110011;
    kind       = rand_bits(3);
    case (kind)
      8'd0: ins.opcode = OPC_LUI;
      8'd1:
      begin
        ins.opcode    = 7'b0000011;
        ins.resultsrc = RES_LOAD;
      end
      8'd2:
      begin
        ins.opcode = 7'b1110011;
        ins.iscsr  = 1'b1;
      end
      8'd3: ins.is_mul = 1'b1;
      8'd4: ins.is_div = 1'b1;
      8'd5:
      begin
        ins.opcode = 7'b0100011;
        ins.regw   = 1'b0;
      end
      default: ;
    endcase
    return ins;
  endfunction

  // Fetch repeats the same instruction while the PC is held.
  task automatic drive_inputs();
    if (!hold_fetch)
    begin
      instr = gen_instr();
    end
    pcsrc        = (rand_bits(3) == 8'd0);
    dcache_stall = (rand_bits(3) == 8'd0);
  endtask

  ////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////

  function automatic fwd_sel_t ref_fwd(
    input logic [4:0] src,
    input hzd_instr_t m,
    input hzd_instr_t w
  );
    fwd_sel_t sel;
    sel = FWD_NONE;
    if (w.regw && (w.rd != 5'd0) && (w.rd == src))
    begin
      sel = FWD_WB;
    end
    // Memory is younger, so it overrides writeback.
    if (m.regw && (m.rd != 5'd0) && (m.rd == src))
    begin
      sel = (m.opcode == OPC_LUI) ? FWD_MEM_LUI : FWD_MEM;
    end
    return sel;
  endfunction

  function automatic hzd_resp_t ref_resp(
    input hzd_instr_t d,
    input hzd_instr_t e,
    input hzd_instr_t m,
    input hzd_instr_t w,
    input logic       pc_taken,
    input logic       dc_stall,
    input int         cnt
  );
    hzd_resp_t r;
    logic      load_use;
    logic      long_wait;
    logic      gstall;
    r         = '0;
    r.fwd_a   = ref_fwd(e.rs1, m, w);
    r.fwd_b   = ref_fwd(e.rs2, m, w);
    load_use  = ((d.rs1 == e.rd) || (d.rs2 == e.rd)) &&
                ((e.resultsrc == RES_LOAD) || (e.iscsr && !d.iscsr));
    long_wait = (e.is_mul || e.is_div) && (cnt != MULDIV_LAT - 1);
    gstall    = dc_stall || long_wait;
    r.ctrl.stallpc = load_use || gstall;
    r.ctrl.stallfd = load_use || gstall;
    r.ctrl.flushfd = pc_taken;
    r.ctrl.flushde = load_use || pc_taken;
    r.ctrl.stallde = gstall;
    r.ctrl.stallem = gstall;
    r.ctrl.stallmw = gstall;
    r.ctrl.passwb  = m.iscsr && w.iscsr;
    return r;
  endfunction

  // Moves the shadow pipeline across the coming edge.
  task automatic advance_shadow(input hzd_ctrl_t c);
    logic long_wait;
    long_wait = (sh_e.is_mul || sh_e.is_div) && (sh_cnt != MULDIV_LAT - 1);
    if (!c.stallde)
    begin
      sh_cnt = 0;
    end
    else if (long_wait)
    begin
      sh_cnt++;
    end
    // Stages update back to front so each takes the old value ahead of it.
    if (!c.stallmw)
    begin
      sh_w = sh_m;
    end
    if (!c.stallem)
    begin
      sh_m = sh_e;
    end
    if (!c.stallde)
    begin
      sh_e = c.flushde ? INSTR_BUBBLE : sh_d;
    end
    if (!c.stallfd)
    begin
      sh_d = c.flushfd ? INSTR_BUBBLE : instr;
    end
    hold_fetch = c.stallpc;
  endtask

  ////////////////////////////////////////////////////////////
  // Checking
  ////////////////////////////////////////////////////////////

  task automatic check_fwd(input string name, input fwd_sel_t got, input fwd_sel_t want);
    if (got !== want)
    begin
      err_cnt++;
      $display("MISMATCH %s got %h expected %h at %0t", name, got, want, $time);
    end
  endtask

  task automatic check_ctrl(input hzd_ctrl_t got, input hzd_ctrl_t want);
    if (got !== want)
    begin
      err_cnt++;
      $display("MISMATCH o_ctrl got %h expected %h at %0t", got, want, $time);
    end
  endtask

  task automatic note_coverage(input hzd_resp_t r);
    if ((r.fwd_a == FWD_MEM_LUI) || (r.fwd_b == FWD_MEM_LUI))
    begin
      seen_lui++;
    end
    if (r.ctrl.flushde && !pcsrc)
    begin
      seen_load_use++;
    end
    if (r.ctrl.stallde && !dcache_stall)
    begin
      seen_muldiv++;
    end
    if (r.ctrl.passwb)
    begin
      seen_passwb++;
    end
  endtask

  // Compares the DUT with the shadow pipeline, then moves the shadow across the edge.
  always @(negedge clk)
  begin : compare_proc
    hzd_resp_t want;
    if (rst_n !== 1'b1)
    begin
      sh_d       = INSTR_BUBBLE;
      sh_e       = INSTR_BUBBLE;
      sh_m       = INSTR_BUBBLE;
      sh_w       = INSTR_BUBBLE;
      sh_cnt     = 0;
      hold_fetch = 1'b0;
    end
    else
    begin
      want = ref_resp(sh_d, sh_e, sh_m, sh_w, pcsrc, dcache_stall, sh_cnt);
      check_fwd("o_fwd_a", fwd_a, want.fwd_a);
      check_fwd("o_fwd_b", fwd_b, want.fwd_b);
      check_ctrl(ctrl, want.ctrl);
      check_cnt++;
      note_coverage(want);
      advance_shadow(want.ctrl);
    end
  end

  task automatic require_seen(input int hits, input string what);
    if (hits == 0)
    begin
      err_cnt++;
      $display("The random stimulus never produced %s", what);
    end
  endtask

  initial
  begin
    rst_n         = 1'b0;
    instr         = '0;
    pcsrc         = 1'b0;
    dcache_stall  = 1'b0;
    hold_fetch    = 1'b0;
    lfsr_state    = 16'd16;
    err_cnt       = 0;
    check_cnt     = 0;
    seen_lui      = 0;
    seen_load_use = 0;
    seen_muldiv   = 0;
    seen_passwb   = 0;
    repeat (RST_CYCLES) @(posedge clk);
    #2;
    rst_n = 1'b1;
    for (int n = 0; n < NUM_CYCLES; n++)
    begin
      @(posedge clk);
      #2;
      drive_inputs();
    end
    @(posedge clk);
    #5;
    require_seen(seen_lui, "an LUI forward from memory");
    require_seen(seen_load_use, "a load-use stall");
    require_seen(seen_muldiv, "a multiply or divide stall");
    require_seen(seen_passwb, "back to back CSR instructions");
    $display("checks %0d, error count %0d", check_cnt, err_cnt);
    if (err_cnt == 0)
    begin
      $display("No errors");
    end
    else
    begin
      $display("Errors found");
    end
    $finish;
  end

  // Watchdog.
  initial
  begin
    #((RST_CYCLES + NUM_CYCLES + 50) * CLK_PERIOD);
    $display("Timeout, the test sequence did not finish in time");
    $display("Errors found");
    $finish;
  end

endmodule

`default_nettype wire
